// File: logic/noc_log_config.svh
`ifndef NOC_LOG_CONFIG_SVH
`define NOC_LOG_CONFIG_SVH

// Flit word layout
`define NOC_FLIT_WIDTH 32
`define NOC_FLIT_ID_WIDTH 8
`define NOC_FLIT_FLAGS_WIDTH 4

// Mesh geometry
`define NOC_ROUTER_ID_WIDTH 8
`define NOC_MESH_SIZE_X 4

// One bit per route target in rc_result
`define NOC_CHANNELS 7

`define NOC_BUFFER_CREDIT_WIDTH 4

// Log queue
`define NOC_LOG_DEPTH 8
`define NOC_LOG_EVENTS 8

`endif

// File: logic/noc_flit_pkg.sv
`include "noc_log_config.svh"

package noc_flit_pkg;

  typedef enum logic [1:0] {
    flit_tail = 2'b01,
    flit_head = 2'b10,
    flit_body = 2'b11
  } flit_type_e;

  // Type on top, flags at the bottom
  typedef struct packed {
    flit_type_e flit_type;
    logic [`NOC_FLIT_WIDTH-`NOC_FLIT_ID_WIDTH-`NOC_FLIT_FLAGS_WIDTH-3:0] data;
    logic [`NOC_FLIT_ID_WIDTH-1:0] flit_id;
    logic [`NOC_FLIT_FLAGS_WIDTH-1:0] flags;
  } flit_t;

  // Code 00 is not a legal state
  typedef enum logic [1:0] {
    state_idle_rc = 2'b01,
    state_sa = 2'b10,
    state_st = 2'b11
  } router_state_e;

  typedef struct packed {
    logic [`NOC_ROUTER_ID_WIDTH-1:0] router_id;
    logic [2:0] port;
    logic vc;
  } endpoint_t;

  typedef struct packed {
    logic [2:0] int_port;
    logic int_vc;
    logic signed [`NOC_ROUTER_ID_WIDTH-1:0] dest_offset;
    logic [2:0] out_port;
    logic out_vc;
  } route_decision_t;

  function automatic endpoint_t channel_endpoint(
    input logic [`NOC_ROUTER_ID_WIDTH-1:0] router_id,
    input int unsigned channel
  );
    endpoint_t ep;
    ep.router_id = router_id;
    ep.vc = 1'b0;
    case (channel)
      0: ep.port = 3'd0;
      1: ep.port = 3'd1;
      2: begin
        ep.port = 3'd1;
        ep.vc = 1'b1;
      end
      3: ep.port = 3'd2;
      4: begin
        ep.port = 3'd2;
        ep.vc = 1'b1;
      end
      5: ep.port = 3'd3;
      6: ep.port = 3'd4;
      default: ep.port = 3'b111;
    endcase
    return ep;
  endfunction

endpackage

// File: logic/noc_log_pkg.sv
`include "noc_log_config.svh"

package noc_log_pkg;

  typedef enum logic [2:0] {
    log_receive = 3'd0,
    log_route = 3'd1,
    log_assign = 3'd2,
    log_switch = 3'd3,
    log_send = 3'd4,
    log_assign_end = 3'd5,
    log_route_end = 3'd6,
    log_state = 3'd7
  } log_event_e;

  // Flit movement, from one endpoint to another
  typedef struct packed {
    noc_flit_pkg::endpoint_t src;
    noc_flit_pkg::endpoint_t dst;
  } flit_view_t;

  typedef struct packed {
    noc_flit_pkg::endpoint_t local_ep;
    noc_flit_pkg::router_state_e prev_state;
    noc_flit_pkg::router_state_e new_state;
    logic [7:0] pad;
  } state_view_t;

  // Event code selects the view
  typedef union packed {
    flit_view_t flit;
    state_view_t state;
  } log_payload_u;

  // Flit type and id are zero for state records
  typedef struct packed {
    log_event_e code;
    noc_flit_pkg::flit_type_e flit_type;
    logic [`NOC_FLIT_ID_WIDTH-1:0] flit_id;
    log_payload_u payload;
  } log_record_t;

  // Events seen at one sampling edge
  typedef struct packed {
    logic receive;
    logic grant;
    logic traversal;
    logic tail;
    logic state_change;
    noc_flit_pkg::flit_t rx_flit;
    noc_flit_pkg::flit_t sm_flit;
    noc_flit_pkg::router_state_e prev_state;
    noc_flit_pkg::router_state_e new_state;
  } capture_t;

endpackage

// File: logic/flit_capture.sv
`include "noc_log_config.svh"

module flit_capture (
  input  logic                                 CLK,
  input  logic                                 rc_success,
  input  noc_flit_pkg::flit_t                  buffer_data_in,
  input  logic                                 buffer_write,
  input  logic [`NOC_BUFFER_CREDIT_WIDTH-1:0]  buffer_credits,
  input  noc_flit_pkg::flit_t                  statemachine_data_in,
  input  logic                                 sa_grant,
  input  logic                                 st_data_valid,
  input  noc_flit_pkg::router_state_e          current_state,
  output noc_log_pkg::capture_t                capture
);

  logic receive_q;
  logic grant_q;
  logic traversal_q;
  logic tail_q;
  logic state_change_q;
  noc_flit_pkg::flit_t rx_flit_q;
  noc_flit_pkg::flit_t sm_flit_q;
  noc_flit_pkg::router_state_e state_q;
  noc_flit_pkg::router_state_e prev_q;
  logic state_valid;

  assign state_valid = current_state != 2'b00;

  always_ff @(posedge CLK or posedge rc_success) begin
    if (rc_success) begin
      receive_q <= 1'b0;
      grant_q <= 1'b0;
      traversal_q <= 1'b0;
      tail_q <= 1'b0;
      state_change_q <= 1'b0;
      state_q <= noc_flit_pkg::state_idle_rc;
    end else begin
      // No credit means the buffer refuses the write
      receive_q <= buffer_write && (buffer_credits != '0);
      grant_q <= sa_grant;
      traversal_q <= st_data_valid;
      tail_q <= st_data_valid && (statemachine_data_in.flit_type == noc_flit_pkg::flit_tail);
      state_change_q <= state_valid && (current_state != state_q);
      if (state_valid) begin
        state_q <= current_state;
      end
    end
  end

  always_ff @(posedge CLK) begin
    rx_flit_q <= buffer_data_in;
    sm_flit_q <= statemachine_data_in;
    if (state_valid && (current_state != state_q)) begin
      prev_q <= state_q;
    end
  end

  // New state is the stored one after the update
  assign capture = '{receive_q, grant_q, traversal_q, tail_q, state_change_q,
                     rx_flit_q, sm_flit_q, prev_q, state_q};

  a_state_legal: assert property (
    @(posedge CLK) disable iff (rc_success) current_state != 2'b00
  );

endmodule

// File: logic/route_decoder.sv
`include "noc_log_config.svh"

module route_decoder (
  input  logic                         CLK,
  input  logic                         rc_success,
  input  logic                         route_done,
  input  logic [`NOC_CHANNELS-1:0]     rc_result,
  output noc_flit_pkg::route_decision_t decision,
  output logic                         route_fired
);

  localparam logic signed [`NOC_ROUTER_ID_WIDTH-1:0] MESH_STEP = `NOC_MESH_SIZE_X;
  localparam logic signed [`NOC_ROUTER_ID_WIDTH-1:0] UNIT_STEP = 1;

  noc_flit_pkg::route_decision_t decision_q;
  noc_flit_pkg::route_decision_t next_decision;

  // Fields: internal port, internal vc, offset, output port, output vc
  always_comb begin
    next_decision = decision_q;
    case (1'b1)
      rc_result[0]: next_decision = '{3'd0, 1'b0, '0, 3'd0, 1'b0};
      rc_result[1]: next_decision = '{3'd1, 1'b0, -MESH_STEP, 3'd2, 1'b0};
      rc_result[2]: next_decision = '{3'd1, 1'b1, -MESH_STEP, 3'd2, 1'b1};
      rc_result[3]: next_decision = '{3'd2, 1'b0, MESH_STEP, 3'd1, 1'b0};
      rc_result[4]: next_decision = '{3'd2, 1'b1, MESH_STEP, 3'd1, 1'b1};
      rc_result[5]: next_decision = '{3'd3, 1'b0, -UNIT_STEP, 3'd4, 1'b0};
      rc_result[6]: next_decision = '{3'd4, 1'b0, UNIT_STEP, 3'd3, 1'b0};
      default: next_decision = decision_q;
    endcase
  end

  always_ff @(posedge CLK or posedge rc_success) begin
    if (rc_success) begin
      decision_q <= '0;
      route_fired <= 1'b0;
    end else begin
      route_fired <= route_done;
      // Ambiguous results leave the last route in place
      if (route_done && $onehot(rc_result)) begin
        decision_q <= next_decision;
      end
    end
  end

  assign decision = decision_q;

  a_result_onehot: assert property (
    @(posedge CLK) disable iff (rc_success) route_done |-> $onehot(rc_result)
  );

endmodule

// File: logic/event_encoder.sv
`include "noc_log_config.svh"

module event_encoder #(
  parameter int unsigned LOCAL_CHANNEL = 0
) (
  input  logic [`NOC_ROUTER_ID_WIDTH-1:0]                 router_id,
  input  noc_log_pkg::capture_t                           capture,
  input  noc_flit_pkg::route_decision_t                   decision,
  input  logic                                            route_fired,
  output noc_log_pkg::log_record_t [`NOC_LOG_EVENTS-1:0] records,
  output logic [`NOC_LOG_EVENTS-1:0]                      write_mask
);

  // Flits from outside have no source
  localparam noc_flit_pkg::endpoint_t NO_EP = '1;

  noc_flit_pkg::endpoint_t local_ep;
  noc_flit_pkg::endpoint_t internal_ep;
  noc_flit_pkg::endpoint_t out_ep;
  noc_log_pkg::state_view_t state_view;

  function automatic noc_log_pkg::log_record_t flit_record(
    input noc_log_pkg::log_event_e code,
    input noc_flit_pkg::endpoint_t src,
    input noc_flit_pkg::endpoint_t dst,
    input noc_flit_pkg::flit_t flit
  );
    noc_log_pkg::log_record_t rec;
    rec.code = code;
    rec.flit_type = flit.flit_type;
    rec.flit_id = flit.flit_id;
    rec.payload.flit.src = src;
    rec.payload.flit.dst = dst;
    return rec;
  endfunction

  if (LOCAL_CHANNEL > `NOC_CHANNELS - 1) begin : g_channel_check
    $error("event_encoder: LOCAL_CHANNEL %0d out of range", LOCAL_CHANNEL);
  end

  assign local_ep = noc_flit_pkg::channel_endpoint(router_id, LOCAL_CHANNEL);
  assign internal_ep = '{router_id, decision.int_port, decision.int_vc};
  // Offset wraps in router id width
  assign out_ep = '{router_id + $unsigned(decision.dest_offset),
                    decision.out_port, decision.out_vc};
  assign state_view = '{local_ep, capture.prev_state, capture.new_state, 8'h00};

  always_comb begin
    noc_log_pkg::log_record_t state_rec;
    state_rec.code = noc_log_pkg::log_state;
    state_rec.flit_type = noc_flit_pkg::flit_type_e'(2'b00);
    state_rec.flit_id = '0;
    state_rec.payload.state = state_view;

    records[noc_log_pkg::log_receive] =
      flit_record(noc_log_pkg::log_receive, NO_EP, local_ep, capture.rx_flit);
    records[noc_log_pkg::log_route] =
      flit_record(noc_log_pkg::log_route, local_ep, internal_ep, capture.sm_flit);
    records[noc_log_pkg::log_assign] =
      flit_record(noc_log_pkg::log_assign, local_ep, internal_ep, capture.sm_flit);
    records[noc_log_pkg::log_switch] =
      flit_record(noc_log_pkg::log_switch, local_ep, internal_ep, capture.sm_flit);
    records[noc_log_pkg::log_send] =
      flit_record(noc_log_pkg::log_send, internal_ep, out_ep, capture.sm_flit);
    records[noc_log_pkg::log_assign_end] =
      flit_record(noc_log_pkg::log_assign_end, local_ep, internal_ep, capture.sm_flit);
    records[noc_log_pkg::log_route_end] =
      flit_record(noc_log_pkg::log_route_end, local_ep, internal_ep, capture.sm_flit);
    records[noc_log_pkg::log_state] = state_rec;
  end

  // Bit position equals the event code
  assign write_mask = {
    capture.state_change,
    capture.tail,
    capture.tail,
    capture.traversal,
    capture.traversal,
    capture.grant,
    route_fired,
    capture.receive
  };

endmodule

// File: logic/log_fifo.sv
`include "noc_log_config.svh"

module log_fifo (
  input  logic                                            CLK,
  input  logic                                            rc_success,
  input  noc_log_pkg::log_record_t [`NOC_LOG_EVENTS-1:0] records,
  input  logic [`NOC_LOG_EVENTS-1:0]                      write_mask,
  output logic                                            log_valid,
  output noc_log_pkg::log_record_t                        log_record,
  output logic                                            log_overflow
);

  localparam int unsigned DEPTH = `NOC_LOG_DEPTH;
  localparam int unsigned EVENTS = `NOC_LOG_EVENTS;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  noc_log_pkg::log_record_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] space;
  logic [PTR_W-1:0] wr_addr [EVENTS];
  logic [EVENTS-1:0] wr_take;
  logic [CNT_W-1:0] n_written;
  logic rd_en;
  logic dropped;

  assign space = CNT_W'(DEPTH) - count_q;
  assign rd_en = count_q != '0;

  // Pack the masked records into consecutive slots, lowest code first
  always_comb begin
    int unsigned seen;
    seen = 0;
    for (int i = 0; i < EVENTS; i++) begin
      wr_addr[i] = wr_ptr + PTR_W'(seen);
      wr_take[i] = write_mask[i] && (seen < space);
      if (write_mask[i]) begin
        seen = seen + 1;
      end
    end
  end

  assign n_written = CNT_W'($countones(wr_take));
  assign dropped = |(write_mask & ~wr_take);

  always_ff @(posedge CLK or posedge rc_success) begin
    if (rc_success) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count_q <= '0;
      log_valid <= 1'b0;
      log_overflow <= 1'b0;
    end else begin
      wr_ptr <= wr_ptr + PTR_W'(n_written);
      count_q <= count_q + n_written - CNT_W'(rd_en);
      log_valid <= rd_en;
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Sticky until reset
      if (dropped) begin
        log_overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    for (int i = 0; i < EVENTS; i++) begin
      if (wr_take[i]) begin
        mem[wr_addr[i]] <= records[i];
      end
    end
    if (rd_en) begin
      log_record <= mem[rd_ptr];
    end
  end

  a_count_bound: assert property (
    @(posedge CLK) disable iff (rc_success) count_q <= CNT_W'(DEPTH)
  );

endmodule

// File: logic/noc_event_logger.sv
`include "noc_log_config.svh"

module noc_event_logger #(
  parameter int unsigned LOCAL_CHANNEL = 0
) (
  input  logic                                CLK,
  input  logic                                rc_success,
  input  logic [`NOC_ROUTER_ID_WIDTH-1:0]     router_id,
  input  noc_flit_pkg::flit_t                 buffer_data_in,
  input  logic                                buffer_write,
  input  logic [`NOC_BUFFER_CREDIT_WIDTH-1:0] buffer_credits,
  input  noc_flit_pkg::flit_t                 statemachine_data_in,
  input  logic                                route_done,
  input  logic [`NOC_CHANNELS-1:0]            rc_result,
  input  logic                                sa_grant,
  input  logic                                st_data_valid,
  input  noc_flit_pkg::router_state_e         current_state,
  output logic                                log_valid,
  output noc_log_pkg::log_record_t            log_record,
  output logic                                log_overflow
);

  noc_log_pkg::capture_t capture;
  noc_flit_pkg::route_decision_t decision;
  logic route_fired;
  noc_log_pkg::log_record_t [`NOC_LOG_EVENTS-1:0] records;
  logic [`NOC_LOG_EVENTS-1:0] write_mask;

  flit_capture u_flit_capture (
    .CLK                  (CLK),
    .rc_success           (rc_success),
    .buffer_data_in       (buffer_data_in),
    .buffer_write         (buffer_write),
    .buffer_credits       (buffer_credits),
    .statemachine_data_in (statemachine_data_in),
    .sa_grant             (sa_grant),
    .st_data_valid        (st_data_valid),
    .current_state        (current_state),
    .capture              (capture)
  );

  route_decoder u_route_decoder (
    .CLK         (CLK),
    .rc_success  (rc_success),
    .route_done  (route_done),
    .rc_result   (rc_result),
    .decision    (decision),
    .route_fired (route_fired)
  );

  event_encoder #(
    .LOCAL_CHANNEL (LOCAL_CHANNEL)
  ) u_event_encoder (
    .router_id   (router_id),
    .capture     (capture),
    .decision    (decision),
    .route_fired (route_fired),
    .records     (records),
    .write_mask  (write_mask)
  );

  log_fifo u_log_fifo (
    .CLK          (CLK),
    .rc_success   (rc_success),
    .records      (records),
    .write_mask   (write_mask),
    .log_valid    (log_valid),
    .log_record   (log_record),
    .log_overflow (log_overflow)
  );

endmodule

// File: tests/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: test, write, credits, rx type, route_done, rc_result,
// grant, st valid, sm flit type, state, expected event mask (bit = code)
typedef struct packed {
  logic [2:0] test_id;
  logic buffer_write;
  logic [`NOC_BUFFER_CREDIT_WIDTH-1:0] credits;
  logic [1:0] rx_type;
  logic route_done;
  logic [`NOC_CHANNELS-1:0] rc_result;
  logic sa_grant;
  logic st_valid;
  logic [1:0] sm_type;
  logic [1:0] state;
  logic [`NOC_LOG_EVENTS-1:0] expect_mask;
} vector_t;

localparam int NUM_VECTORS = 32;
localparam logic [2:0] OVERFLOW_TEST = 3'd5;

localparam vector_t VECTORS [NUM_VECTORS] = '{
  '{3'd1, 1'b1, 4'd3, 2'b10, 1'b0, 7'h00, 1'b0, 1'b0, 2'b10, 2'b01, 8'h01},
  '{3'd1, 1'b1, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b0, 2'b10, 2'b01, 8'h00},
  // Route, traversal, idle for each result bit
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b1, 7'h02, 1'b0, 1'b0, 2'b10, 2'b01, 8'h02},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b1, 2'b11, 2'b01, 8'h18},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b0, 2'b10, 2'b01, 8'h00},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b1, 7'h01, 1'b0, 1'b0, 2'b10, 2'b01, 8'h02},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b1, 2'b11, 2'b01, 8'h18},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b0, 2'b10, 2'b01, 8'h00},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b1, 7'h04, 1'b0, 1'b0, 2'b10, 2'b01, 8'h02},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b1, 2'b11, 2'b01, 8'h18},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b0, 2'b10, 2'b01, 8'h00},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b1, 7'h08, 1'b0, 1'b0, 2'b10, 2'b01, 8'h02},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b1, 2'b11, 2'b01, 8'h18},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b0, 2'b10, 2'b01, 8'h00},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b1, 7'h10, 1'b0, 1'b0, 2'b10, 2'b01, 8'h02},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b1, 2'b11, 2'b01, 8'h18},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b0, 2'b10, 2'b01, 8'h00},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b1, 7'h20, 1'b0, 1'b0, 2'b10, 2'b01, 8'h02},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b1, 2'b11, 2'b01, 8'h18},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b0, 2'b10, 2'b01, 8'h00},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b1, 7'h40, 1'b0, 1'b0, 2'b10, 2'b01, 8'h02},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b1, 2'b11, 2'b01, 8'h18},
  '{3'd2, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b0, 2'b10, 2'b01, 8'h00},
  '{3'd3, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b1, 1'b0, 2'b10, 2'b01, 8'h04},
  '{3'd3, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b1, 2'b01, 2'b01, 8'h78},
  '{3'd4, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b0, 2'b10, 2'b10, 8'h80},
  '{3'd4, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b0, 2'b10, 2'b11, 8'h80},
  '{3'd4, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b0, 2'b10, 2'b01, 8'h80},
  '{3'd4, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b0, 2'b10, 2'b01, 8'h00},
  // Second burst finds the queue full
  '{3'd5, 1'b1, 4'd5, 2'b11, 1'b1, 7'h08, 1'b1, 1'b1, 2'b01, 2'b10, 8'hff},
  '{3'd5, 1'b1, 4'd5, 2'b11, 1'b1, 7'h10, 1'b1, 1'b1, 2'b01, 2'b11, 8'h00},
  '{3'd5, 1'b0, 4'd0, 2'b10, 1'b0, 7'h00, 1'b0, 1'b0, 2'b10, 2'b11, 8'h00}
};

function automatic string test_name(input logic [2:0] test_id);
  case (test_id)
    3'd1: return "receive";
    3'd2: return "route decode";
    3'd3: return "grant and tail";
    3'd4: return "state change";
    3'd5: return "overflow";
    default: return "unknown";
  endcase
endfunction

`endif

// File: tests/tb_noc_event_logger.sv
`include "noc_log_config.svh"

module tb_noc_event_logger;

  localparam int CLK_PERIOD = 40;
  localparam int LOCAL_CHANNEL = 2;
  localparam logic [`NOC_ROUTER_ID_WIDTH-1:0] ROUTER_ID = 8'h25;
  localparam logic [`NOC_ROUTER_ID_WIDTH-1:0] MESH_X = `NOC_MESH_SIZE_X;

  `include "tb_vectors.svh"

  // Channel 2 sits on port 1 vc 1
  localparam logic [2:0] LOCAL_PORT = 3'd1;
  localparam logic LOCAL_VC = 1'b1;

  typedef struct packed {
    logic [2:0] int_port;
    logic int_vc;
    logic [`NOC_ROUTER_ID_WIDTH-1:0] offset;
    logic [2:0] out_port;
    logic out_vc;
  } route_model_t;

  logic CLK;
  logic rc_success;
  logic [`NOC_ROUTER_ID_WIDTH-1:0] router_id;
  noc_flit_pkg::flit_t buffer_data_in;
  logic buffer_write;
  logic [`NOC_BUFFER_CREDIT_WIDTH-1:0] buffer_credits;
  noc_flit_pkg::flit_t statemachine_data_in;
  logic route_done;
  logic [`NOC_CHANNELS-1:0] rc_result;
  logic sa_grant;
  logic st_data_valid;
  noc_flit_pkg::router_state_e current_state;
  logic log_valid;
  noc_log_pkg::log_record_t log_record;
  logic log_overflow;

  noc_log_pkg::log_record_t expected [$];
  route_model_t model_route;
  logic [1:0] model_state;
  int seed;
  int checks;
  int errors;

  noc_event_logger #(
    .LOCAL_CHANNEL (LOCAL_CHANNEL)
  ) u_noc_event_logger (
    .CLK                  (CLK),
    .rc_success           (rc_success),
    .router_id            (router_id),
    .buffer_data_in       (buffer_data_in),
    .buffer_write         (buffer_write),
    .buffer_credits       (buffer_credits),
    .statemachine_data_in (statemachine_data_in),
    .route_done           (route_done),
    .rc_result            (rc_result),
    .sa_grant             (sa_grant),
    .st_data_valid        (st_data_valid),
    .current_state        (current_state),
    .log_valid            (log_valid),
    .log_record           (log_record),
    .log_overflow         (log_overflow)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  function automatic noc_flit_pkg::endpoint_t endpoint_of(
    input logic [`NOC_ROUTER_ID_WIDTH-1:0] rid,
    input logic [2:0] port,
    input logic vc
  );
    noc_flit_pkg::endpoint_t ep;
    ep.router_id = rid;
    ep.port = port;
    ep.vc = vc;
    return ep;
  endfunction

  // Route table by result bit
  function automatic route_model_t route_for(input logic [`NOC_CHANNELS-1:0] result);
    route_model_t r;
    r = '0;
    for (int b = 0; b < `NOC_CHANNELS; b++) begin
      if (result[b]) begin
        case (b)
          1: r = '{3'd1, 1'b0, 8'd0 - MESH_X, 3'd2, 1'b0};
          2: r = '{3'd1, 1'b1, 8'd0 - MESH_X, 3'd2, 1'b1};
          3: r = '{3'd2, 1'b0, MESH_X, 3'd1, 1'b0};
          4: r = '{3'd2, 1'b1, MESH_X, 3'd1, 1'b1};
          5: r = '{3'd3, 1'b0, 8'hff, 3'd4, 1'b0};
          6: r = '{3'd4, 1'b0, 8'h01, 3'd3, 1'b0};
          default: r = '0;
        endcase
      end
    end
    return r;
  endfunction

  task automatic expect_flit(
    input logic [2:0] code,
    input noc_flit_pkg::endpoint_t src,
    input noc_flit_pkg::endpoint_t dst,
    input noc_flit_pkg::flit_t flit
  );
    noc_log_pkg::log_record_t rec;
    rec.code = noc_log_pkg::log_event_e'(code);
    rec.flit_type = flit.flit_type;
    rec.flit_id = flit.flit_id;
    rec.payload.flit.src = src;
    rec.payload.flit.dst = dst;
    expected.push_back(rec);
  endtask

  task automatic expect_state(
    input noc_flit_pkg::endpoint_t ep,
    input logic [1:0] prev_state,
    input logic [1:0] new_state
  );
    noc_log_pkg::log_record_t rec;
    rec = '0;
    rec.code = noc_log_pkg::log_state;
    rec.payload.state.local_ep = ep;
    rec.payload.state.prev_state = noc_flit_pkg::router_state_e'(prev_state);
    rec.payload.state.new_state = noc_flit_pkg::router_state_e'(new_state);
    expected.push_back(rec);
  endtask

  task automatic apply_row(input vector_t row);
    noc_flit_pkg::flit_t rx_flit;
    noc_flit_pkg::flit_t sm_flit;
    noc_flit_pkg::endpoint_t local_ep;
    noc_flit_pkg::endpoint_t internal_ep;
    noc_flit_pkg::endpoint_t out_ep;
    logic [1:0] prev_state;
    rx_flit = noc_flit_pkg::flit_t'($random(seed));
    rx_flit.flit_type = noc_flit_pkg::flit_type_e'(row.rx_type);
    sm_flit = noc_flit_pkg::flit_t'($random(seed));
    sm_flit.flit_type = noc_flit_pkg::flit_type_e'(row.sm_type);
    @(posedge CLK);
    buffer_data_in <= rx_flit;
    buffer_write <= row.buffer_write;
    buffer_credits <= row.credits;
    statemachine_data_in <= sm_flit;
    route_done <= row.route_done;
    rc_result <= row.rc_result;
    sa_grant <= row.sa_grant;
    st_data_valid <= row.st_valid;
    current_state <= noc_flit_pkg::router_state_e'(row.state);
    // Decision for this row takes effect on its own records
    if (row.route_done && $onehot(row.rc_result)) begin
      model_route = route_for(row.rc_result);
    end
    prev_state = model_state;
    model_state = row.state;
    local_ep = endpoint_of(router_id, LOCAL_PORT, LOCAL_VC);
    internal_ep = endpoint_of(router_id, model_route.int_port, model_route.int_vc);
    out_ep = endpoint_of(router_id + model_route.offset, model_route.out_port,
                         model_route.out_vc);
    for (int code = 0; code < `NOC_LOG_EVENTS; code++) begin
      if (row.expect_mask[code]) begin
        case (code)
          0: expect_flit(3'(code), '1, local_ep, rx_flit);
          4: expect_flit(3'(code), internal_ep, out_ep, sm_flit);
          7: expect_state(local_ep, prev_state, model_state);
          default: expect_flit(3'(code), local_ep, internal_ep, sm_flit);
        endcase
      end
    end
  endtask

  task automatic check_output();
    noc_log_pkg::log_record_t want;
    checks++;
    assert (expected.size() > 0) else begin
      $display("Error: unexpected record %h at time %0t, none was expected", log_record, $time);
      errors++;
    end
    if (expected.size() > 0) begin
      want = expected.pop_front();
      assert (log_record == want) else begin
        $display("Error: time %0t signal log_record expected %h actual %h",
                 $time, want, log_record);
        errors++;
      end
    end
  endtask

  // Outputs settle after the rising edge
  always @(negedge CLK) begin
    if (!rc_success && log_valid) begin
      check_output();
    end
  end

  task automatic finish_test(input logic [2:0] test_id, input int errors_before);
    int quiet;
    quiet = 0;
    @(posedge CLK);
    buffer_write <= 1'b0;
    route_done <= 1'b0;
    sa_grant <= 1'b0;
    st_data_valid <= 1'b0;
    // A few empty cycles catch stray records
    while (expected.size() != 0 || quiet < 4) begin
      @(posedge CLK);
      if (expected.size() == 0) begin
        quiet++;
      end
    end
    checks++;
    assert (log_overflow == (test_id == OVERFLOW_TEST)) else begin
      $display("Error: time %0t signal log_overflow expected %0d actual %0d",
               $time, test_id == OVERFLOW_TEST, log_overflow);
      errors++;
    end
    $display("Test %0d %s: %0d errors", test_id, test_name(test_id), errors - errors_before);
  endtask

  initial begin
    int test_errors;
    seed = 32'hd20b_944c;
    checks = 0;
    errors = 0;
    model_state = 2'b01;
    model_route = '0;
    rc_success = 1'b1;
    router_id = ROUTER_ID;
    buffer_data_in = '0;
    buffer_write = 1'b0;
    buffer_credits = '0;
    statemachine_data_in = '0;
    route_done = 1'b0;
    rc_result = '0;
    sa_grant = 1'b0;
    st_data_valid = 1'b0;
    current_state = noc_flit_pkg::state_idle_rc;
    repeat (2) @(posedge CLK);
    rc_success <= 1'b0;
    @(negedge CLK);
    checks++;
    assert (!log_valid && !log_overflow) else begin
      $display("Error: outputs are not idle after reset at time %0t", $time);
      errors++;
    end
    test_errors = 0;
    for (int i = 0; i < NUM_VECTORS; i++) begin
      if (i > 0 && VECTORS[i].test_id != VECTORS[i-1].test_id) begin
        finish_test(VECTORS[i-1].test_id, test_errors);
        test_errors = errors;
      end
      apply_row(VECTORS[i]);
    end
    finish_test(VECTORS[NUM_VECTORS-1].test_id, test_errors);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #((NUM_VECTORS + 100) * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", NUM_VECTORS + 100);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: project.f
+incdir+logic
+incdir+tests
logic/noc_flit_pkg.sv
logic/noc_log_pkg.sv
logic/flit_capture.sv
logic/route_decoder.sv
logic/event_encoder.sv
logic/log_fifo.sv
logic/noc_event_logger.sv
tests/tb_noc_event_logger.sv

// File: Makefile
VERILATOR       ?= verilator
TOP             ?= tb_noc_event_logger
FILELIST        ?= project.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
PASS_STRING     ?= Result: PASSED
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS      ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS_STRING)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
